/* iotdf_crc_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module iotdf_crc_unit (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  iotdf_pkg::dec_word_t i_word,
  input  logic                 i_word_valid,
  output iotdf_pkg::crc_t      o_crc,
  output logic                 o_crc_valid
);

  iotdf_pkg::crc_t crc_q;
  logic            crc_valid_q;
  logic            hit;

  // bitwise long division, same result as appending three zero bits
  function automatic iotdf_pkg::crc_t crc_of(input iotdf_pkg::word_t data);
    iotdf_pkg::crc_t rem;
    logic            fb;
    rem = '0;
    for (int i = iotdf_pkg::WORD_W - 1; i >= 0; i--) begin
      fb  = rem[iotdf_pkg::CRC_W-1] ^ data[i];
      rem = {rem[iotdf_pkg::CRC_W-2:0], 1'b0} ^ (fb ? iotdf_pkg::CRC_POLY : '0);
    end
    return rem;
  endfunction

  assign hit = i_word_valid && (i_word.op == iotdf_pkg::FN_CRC_GEN);

  always_ff @(posedge i_clk) begin
    if (hit) begin
      crc_q <= crc_of(i_word.data);
    end
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      crc_valid_q <= 1'b0;
    end else begin
      crc_valid_q <= hit;
    end
  end

  assign o_crc       = crc_q;
  assign o_crc_valid = crc_valid_q;

endmodule

`default_nettype wire

/* iotdf_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module iotdf_decode (
  input  logic                             i_clk,
  input  logic                             i_rst,
  input  logic                             i_in_en,
  input  logic [iotdf_pkg::BYTE_W-1:0]     i_iot_in,
  input  iotdf_pkg::fn_e                   i_fn_sel,
  output iotdf_pkg::dec_word_t             o_word,
  output logic                             o_word_valid
);

  logic [iotdf_pkg::BYTE_CNT_W-1:0] byte_cnt;
  logic [iotdf_pkg::GRP_CNT_W-1:0]  grp_cnt;
  logic [iotdf_pkg::GRP_CNT_W-1:0]  grp_idx;
  iotdf_pkg::fn_e                   op_q;
  iotdf_pkg::fn_e                   prev_op;
  iotdf_pkg::word_t                 word_q;
  logic                             first_q;
  logic                             last_q;
  logic                             word_valid_q;
  logic                             byte_last;
  logic                             new_group;

  assign byte_last = i_in_en && (byte_cnt == iotdf_pkg::LAST_BYTE);

  // opcode change or a wrapped group count starts a fresh group
  assign new_group = (op_q != prev_op) || (grp_cnt == '0);
  assign grp_idx   = new_group ? '0 : grp_cnt;

  // msb first, so each new byte enters at the bottom
  always_ff @(posedge i_clk) begin
    if (i_in_en) begin
      word_q <= {word_q[iotdf_pkg::WORD_W-iotdf_pkg::BYTE_W-1:0], i_iot_in};
    end
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      byte_cnt     <= '0;
      grp_cnt      <= '0;
      op_q         <= iotdf_pkg::fn_e'(3'd0);
      prev_op      <= iotdf_pkg::fn_e'(3'd0);
      first_q      <= 1'b0;
      last_q       <= 1'b0;
      word_valid_q <= 1'b0;
    end else begin
      word_valid_q <= byte_last;
      if (i_in_en) begin
        byte_cnt <= (byte_cnt == iotdf_pkg::LAST_BYTE) ? '0 : byte_cnt + 1'b1;
        // function select rides with the first byte
        if (byte_cnt == '0) begin
          op_q <= i_fn_sel;
        end
      end
      if (byte_last) begin
        first_q <= new_group;
        last_q  <= (grp_idx == iotdf_pkg::LAST_WORD);
        grp_cnt <= (grp_idx == iotdf_pkg::LAST_WORD) ? '0 : grp_idx + 1'b1;
        prev_op <= op_q;
      end
    end
  end

  // op_q only changes on the next byte one, after the consumers sample
  always_comb begin
    o_word.op    = op_q;
    o_word.data  = word_q;
    o_word.first = first_q;
    o_word.last  = last_q;
  end

  assign o_word_valid = word_valid_q;

endmodule

`default_nettype wire

/* iotdf_extreme_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module iotdf_extreme_unit (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  iotdf_pkg::dec_word_t i_word,
  input  logic                 i_word_valid,
  output iotdf_pkg::ext_pair_t o_pair,
  output logic                 o_pair_valid
);

  iotdf_pkg::word_t best_q;
  iotdf_pkg::word_t second_q;
  iotdf_pkg::word_t best_nxt;
  iotdf_pkg::word_t second_nxt;
  logic             is_max;
  logic             hit;
  logic             pair_valid_q;

  // strict unsigned compare in the direction of the running function
  function automatic logic better(input logic max_mode, input iotdf_pkg::word_t a,
                                  input iotdf_pkg::word_t b);
    return max_mode ? (a > b) : (a < b);
  endfunction

  assign is_max = (i_word.op == iotdf_pkg::FN_TOP2MAX);
  assign hit    = i_word_valid && (is_max || (i_word.op == iotdf_pkg::FN_LAST2MIN));

  always_comb begin
    best_nxt   = best_q;
    second_nxt = second_q;
    if (i_word.first) begin
      best_nxt   = i_word.data;
      // worst possible value so any later word displaces it
      second_nxt = is_max ? '0 : '1;
    end else if (better(is_max, i_word.data, best_q)) begin
      best_nxt   = i_word.data;
      second_nxt = best_q;
    end else if (better(is_max, i_word.data, second_q)) begin
      // a repeat of best lands here
      second_nxt = i_word.data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (hit) begin
      best_q   <= best_nxt;
      second_q <= second_nxt;
    end
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      pair_valid_q <= 1'b0;
    end else begin
      pair_valid_q <= hit && i_word.last;
    end
  end

  // pair stays put until the next owned word, at least 16 cycles away
  always_comb begin
    o_pair.best   = best_q;
    o_pair.second = second_q;
  end

  assign o_pair_valid = pair_valid_q;

endmodule

`default_nettype wire

/* iotdf_pkg.sv */
`default_nettype none

package iotdf_pkg;

  // stream and word geometry
  localparam int BYTE_W          = 8;
  localparam int WORD_W          = 128;
  localparam int BYTES_PER_WORD  = 16;
  localparam int WORDS_PER_GROUP = 8;

  // x^3 + x + 1, leading term implied
  localparam int              CRC_W    = 3;
  localparam logic [CRC_W-1:0] CRC_POLY = 3'b011;

  // counter widths and wrap values
  localparam int BYTE_CNT_W = $clog2(BYTES_PER_WORD);
  localparam int GRP_CNT_W  = $clog2(WORDS_PER_GROUP);
  localparam logic [BYTE_CNT_W-1:0] LAST_BYTE = BYTE_CNT_W'(BYTES_PER_WORD - 1);
  localparam logic [GRP_CNT_W-1:0]  LAST_WORD = GRP_CNT_W'(WORDS_PER_GROUP - 1);

  // encrypt and decrypt codes are accepted but produce no result
  typedef enum logic [2:0] {
    FN_ENCRYPT  = 3'd1,
    FN_DECRYPT  = 3'd2,
    FN_CRC_GEN  = 3'd3,
    FN_TOP2MAX  = 3'd4,
    FN_LAST2MIN = 3'd5
  } fn_e;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [CRC_W-1:0]  crc_t;

  // assembled word with its group markers
  typedef struct packed {
    fn_e   op;
    word_t data;
    logic  first;
    logic  last;
  } dec_word_t;

  typedef struct packed {
    word_t best;
    word_t second;
  } ext_pair_t;

  typedef enum logic {
    R_IDLE,
    R_SECOND
  } res_state_e;

endpackage

`default_nettype wire

/* iotdf_result.sv */
`timescale 1ns/1ns
`default_nettype none

module iotdf_result (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  iotdf_pkg::crc_t      i_crc,
  input  logic                 i_crc_valid,
  input  iotdf_pkg::ext_pair_t i_pair,
  input  logic                 i_pair_valid,
  output iotdf_pkg::word_t     o_iot_out,
  output logic                 o_valid
);

  iotdf_pkg::res_state_e state;
  iotdf_pkg::word_t      second_q;

  always_ff @(posedge i_clk) begin
    if (i_pair_valid) begin
      second_q <= i_pair.second;
    end
  end

  // second word of a pair goes out one cycle after the first
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      state <= iotdf_pkg::R_IDLE;
    end else begin
      case (state)
        iotdf_pkg::R_IDLE: begin
          if (i_pair_valid) begin
            state <= iotdf_pkg::R_SECOND;
          end
        end
        iotdf_pkg::R_SECOND: state <= iotdf_pkg::R_IDLE;
        default:             state <= iotdf_pkg::R_IDLE;
      endcase
    end
  end

  // strobes never overlap, order here is only a tie break
  always_comb begin
    o_valid   = 1'b0;
    o_iot_out = '0;
    if (i_pair_valid) begin
      o_valid   = 1'b1;
      o_iot_out = i_pair.best;
    end else if (i_crc_valid) begin
      o_valid   = 1'b1;
      o_iot_out = {{(iotdf_pkg::WORD_W - iotdf_pkg::CRC_W){1'b0}}, i_crc};
    end else if (state == iotdf_pkg::R_SECOND) begin
      o_valid   = 1'b1;
      o_iot_out = second_q;
    end
  end

endmodule

`default_nettype wire

/* iotdf_stimulus.txt */
3 5 0 ffffffffffffffffffffffffffffffff 1 80000000000000000000000000000000 2
0 5 3 6 6
4 10 10 deadbeef 7 1234 deadbeef 0 ff 5
5 2 abcdef 77 1 fffffffff 9 0
deadbeef deadbeef fffffffff abcdef
5 8 ffffffffffffffffffffffffffffffff 300 0 42 7 1000 42 99
0 7
1 1 5555
2 1 aaaa
3 1 4
7
4 3 1 2 3
3 1 10
1
5 8 50 40 60 30 ffff 35 70 31
30 31

/* iotdf_top.sv */
`timescale 1ns/1ns
`default_nettype none

module iotdf_top (
  input  logic                         i_clk,
  input  logic                         i_rst,
  input  logic                         i_in_en,
  input  logic [iotdf_pkg::BYTE_W-1:0] i_iot_in,
  input  iotdf_pkg::fn_e               i_fn_sel,
  output iotdf_pkg::word_t             o_iot_out,
  output logic                         o_valid
);

  iotdf_pkg::dec_word_t word;
  logic                 word_valid;
  iotdf_pkg::crc_t      crc;
  logic                 crc_valid;
  iotdf_pkg::ext_pair_t pair;
  logic                 pair_valid;

  // byte assembly and group markers
  iotdf_decode u_decode (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_in_en      (i_in_en),
    .i_iot_in     (i_iot_in),
    .i_fn_sel     (i_fn_sel),
    .o_word       (word),
    .o_word_valid (word_valid)
  );

  iotdf_crc_unit u_crc (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_word       (word),
    .i_word_valid (word_valid),
    .o_crc        (crc),
    .o_crc_valid  (crc_valid)
  );

  iotdf_extreme_unit u_extreme (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_word       (word),
    .i_word_valid (word_valid),
    .o_pair       (pair),
    .o_pair_valid (pair_valid)
  );

  iotdf_result u_result (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_crc        (crc),
    .i_crc_valid  (crc_valid),
    .i_pair       (pair),
    .i_pair_valid (pair_valid),
    .o_iot_out    (o_iot_out),
    .o_valid      (o_valid)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and judge the run from its log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_iotdf \
  -f sources.f -o sim_iotdf > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_iotdf > sim.log 2>&1
cat sim.log
grep -q "^No errors$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* sources.f */
iotdf_pkg.sv
iotdf_decode.sv
iotdf_crc_unit.sv
iotdf_extreme_unit.sv
iotdf_result.sv
iotdf_top.sv
tb_iotdf_chk.sv
tb_iotdf.sv

/* tb_iotdf.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_iotdf;

  logic                         i_clk = 1'b0;
  logic                         i_rst;
  logic                         i_in_en;
  logic [iotdf_pkg::BYTE_W-1:0] i_iot_in;
  iotdf_pkg::fn_e               i_fn_sel;
  iotdf_pkg::word_t             o_iot_out;
  logic                         o_valid;

  integer seed   = 66;
  int     cycles = 0;
  int     limit  = 0;
  int     fd;

  // one entry per test, words and expected results kept in file order
  iotdf_pkg::fn_e   test_op[$];
  int               test_cnt[$];
  iotdf_pkg::word_t word_list[$];
  iotdf_pkg::word_t exp_list[$];
  iotdf_pkg::word_t got_q[$];

  iotdf_top dut0 (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_in_en   (i_in_en),
    .i_iot_in  (i_iot_in),
    .i_fn_sel  (i_fn_sel),
    .o_iot_out (o_iot_out),
    .o_valid   (o_valid)
  );

  bind iotdf_top tb_iotdf_chk chk0 (.i_clk(i_clk), .i_rst(i_rst), .i_valid(o_valid));

  always #50 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      fail_stop($sformatf("Timeout: expected results did not arrive within %0d cycles", limit));
    end
  end

  // outputs settle well before the falling edge
  always @(negedge i_clk) begin
    if (!i_rst && o_valid) begin
      got_q.push_back(o_iot_out);
    end
  end

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_word(input iotdf_pkg::word_t exp, input iotdf_pkg::word_t got);
    if (got !== exp) begin
      fail_stop($sformatf("** Error at %0t ns: o_iot_out expected %h got %h", $time, exp, got));
    end
  endtask

  task automatic check_crc(input iotdf_pkg::crc_t exp, input iotdf_pkg::word_t got);
    iotdf_pkg::word_t want;
    // crc in the low bits, all upper bits zero
    want = '0;
    want[iotdf_pkg::CRC_W-1:0] = exp;
    if (got !== want) begin
      fail_stop($sformatf("** Error at %0t ns: o_iot_out (crc) expected %h got %h",
                          $time, want, got));
    end
  endtask

  // crc gives one result per word, extremes two per full group
  function automatic int results_for(input iotdf_pkg::fn_e op, input int n_words);
    case (op)
      iotdf_pkg::FN_CRC_GEN:  return n_words;
      iotdf_pkg::FN_TOP2MAX,
      iotdf_pkg::FN_LAST2MIN: return 2 * (n_words / iotdf_pkg::WORDS_PER_GROUP);
      default:                return 0;
    endcase
  endfunction

  // msb first, 0 to 2 idle cycles ahead of every byte
  task automatic send_word(input iotdf_pkg::fn_e op, input iotdf_pkg::word_t w);
    int idle;
    for (int b = iotdf_pkg::BYTES_PER_WORD - 1; b >= 0; b--) begin
      idle = {$random(seed)} % 3;
      repeat (idle) begin
        @(posedge i_clk);
        i_in_en <= 1'b0;
      end
      @(posedge i_clk);
      i_in_en  <= 1'b1;
      i_iot_in <= w[b*iotdf_pkg::BYTE_W +: iotdf_pkg::BYTE_W];
      i_fn_sel <= op;
    end
    @(posedge i_clk);
    i_in_en <= 1'b0;
  endtask

  // each test: opcode, word count, words, then its expected results
  task automatic load_stimulus();
    iotdf_pkg::word_t v;
    iotdf_pkg::fn_e   op;
    int               n;
    fd = $fopen("iotdf_stimulus.txt", "r");
    if (fd == 0) begin
      fail_stop("Cannot open iotdf_stimulus.txt for reading");
    end
    while ($fscanf(fd, "%h", v) == 1) begin
      op = iotdf_pkg::fn_e'(v[2:0]);
      if ($fscanf(fd, "%h", v) != 1) begin
        fail_stop("Stimulus file ends before the word count of a test");
      end
      n = int'(v);
      test_op.push_back(op);
      test_cnt.push_back(n);
      for (int k = 0; k < n + results_for(op, n); k++) begin
        if ($fscanf(fd, "%h", v) != 1) begin
          fail_stop("Stimulus file ends in the middle of a test");
        end
        if (k < n) begin
          word_list.push_back(v);
        end else begin
          exp_list.push_back(v);
        end
      end
    end
    $fclose(fd);
  endtask

  initial begin
    iotdf_pkg::word_t got;
    iotdf_pkg::word_t exp_w;
    int               n_exp;
    int               widx;
    int               eidx;
    i_rst    <= 1'b1;
    i_in_en  <= 1'b0;
    i_iot_in <= '0;
    i_fn_sel <= iotdf_pkg::FN_CRC_GEN;
    load_stimulus();
    // every byte takes at most three cycles
    limit = word_list.size() * iotdf_pkg::BYTES_PER_WORD * 3 + 200;
    repeat (4) @(posedge i_clk);
    i_rst <= 1'b0;
    widx = 0;
    eidx = 0;
    foreach (test_op[t]) begin
      for (int k = 0; k < test_cnt[t]; k++) begin
        send_word(test_op[t], word_list[widx]);
        widx++;
      end
      n_exp = results_for(test_op[t], test_cnt[t]);
      while (got_q.size() < n_exp) begin
        @(negedge i_clk);
      end
      for (int k = 0; k < n_exp; k++) begin
        got   = got_q.pop_front();
        exp_w = exp_list[eidx];
        if (test_op[t] == iotdf_pkg::FN_CRC_GEN) begin
          check_crc(exp_w[iotdf_pkg::CRC_W-1:0], got);
        end else begin
          check_word(exp_w, got);
        end
        eidx++;
      end
    end
    // a late result would show within three cycles of the last byte
    repeat (3) @(negedge i_clk);
    if (got_q.size() != 0) begin
      fail_stop($sformatf("Unexpected extra result on o_iot_out: %h", got_q[0]));
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* tb_iotdf_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_iotdf_chk (
  input logic i_clk,
  input logic i_rst,
  input logic i_valid
);

  logic       valid_d;
  logic       rise;
  logic [4:0] since_rise;

  assign rise = i_valid && !valid_d;

  // cycles since the last rise of o_valid, saturating
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      valid_d    <= 1'b0;
      since_rise <= 5'd31;
    end else begin
      valid_d <= i_valid;
      if (rise) begin
        since_rise <= 5'd1;
      end else if (since_rise != 5'd31) begin
        since_rise <= since_rise + 5'd1;
      end
    end
  end

  a_quiet_in_reset: assert property (@(posedge i_clk) i_rst |-> !i_valid)
    else $error("o_valid high while reset is asserted");

  // a pair is the longest burst
  a_burst_max_two: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_valid && $past(i_valid) && $past(i_valid, 2)))
    else $error("o_valid high for three cycles in a row");

  // a new word needs 16 input cycles
  a_result_spacing: assert property (@(posedge i_clk) disable iff (i_rst)
    rise |-> (since_rise > 5'd15))
    else $error("o_valid rose again within 15 cycles of the previous result");

endmodule

`default_nettype wire
